/* logic/decode_unit.sv */
`include "scpu_defs.svh"

module decode_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  scpu_pkg::ifid_t       ifid,
    input  logic                  redirect,
    output logic                  stall,
    scpu_fwd_if.sink              fwd,
    input  logic [`SCPU_RA_W-1:0] debug_reg_addr,
    output logic [`SCPU_XLEN-1:0] debug_reg_data,
    output scpu_pkg::idex_t       idex
);

    logic [`SCPU_ILEN-1:0] inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [`SCPU_RA_W-1:0] rs1, rs2, rd;
    logic [`SCPU_XLEN-1:0] rs1_val, rs2_val, imm;
    scpu_pkg::ctrl_t       ctrl;
    scpu_pkg::idex_t       idex_d;

    function automatic scpu_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? scpu_pkg::ALU_SUB : scpu_pkg::ALU_ADD;
            3'b001:  return scpu_pkg::ALU_SLL;
            3'b010:  return scpu_pkg::ALU_SLT;
            3'b011:  return scpu_pkg::ALU_SLTU;
            3'b100:  return scpu_pkg::ALU_XOR;
            3'b101:  return alt ? scpu_pkg::ALU_SRA : scpu_pkg::ALU_SRL;
            3'b110:  return scpu_pkg::ALU_OR;
            default: return scpu_pkg::ALU_AND;
        endcase
    endfunction

    assign inst   = ifid.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl = '0;
        if (ifid.valid) begin
            case (opcode)
                `SCPU_OP_LOAD: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.wb_sel      = scpu_pkg::WB_MEM;
                    ctrl.mem_read    = 1'b1;
                end
                `SCPU_OP_STORE: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                end
                `SCPU_OP_BRANCH: ctrl.branch = 1'b1;
                `SCPU_OP_JAL: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = scpu_pkg::WB_PC4;
                    ctrl.jal       = 1'b1;
                end
                `SCPU_OP_JALR: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = scpu_pkg::WB_PC4;
                    ctrl.jalr      = 1'b1;
                end
                `SCPU_OP_LUI: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = scpu_pkg::WB_IMM;
                end
                `SCPU_OP_AUIPC: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.auipc     = 1'b1;
                end
                `SCPU_OP_IMM: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = alu_decode(funct3, inst[30] && funct3 == 3'b101);
                end
                `SCPU_OP_REG: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = alu_decode(funct3, inst[30]);
                end
                default: ctrl = '0;  // unknown opcode runs as a nop
            endcase
        end
    end

    always_comb begin
        case (opcode)
            `SCPU_OP_STORE:
                imm = {{(`SCPU_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            `SCPU_OP_BRANCH:
                imm = {{(`SCPU_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            `SCPU_OP_LUI, `SCPU_OP_AUIPC:
                imm = {{(`SCPU_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            `SCPU_OP_JAL:
                imm = {{(`SCPU_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = {{(`SCPU_XLEN-12){inst[31]}}, inst[31:20]};
        endcase
    end

    // load in ID/EX feeding the instruction in decode
    assign stall = ifid.valid && idex.valid && idex.ctrl.mem_read && idex.rd != '0
                   && (idex.rd == rs1 || idex.rd == rs2);

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .we         (fwd.wb_reg_write),
        .waddr      (fwd.wb_rd),
        .wdata      (fwd.wb_data),
        .raddr1     (rs1),
        .raddr2     (rs2),
        .rdata1     (rs1_val),
        .rdata2     (rs2_val),
        .debug_addr (debug_reg_addr),
        .debug_data (debug_reg_data)
    );

    always_comb begin
        idex_d         = '0;
        idex_d.ctrl    = ctrl;
        idex_d.pc      = ifid.pc;
        idex_d.rs1_val = rs1_val;
        idex_d.rs2_val = rs2_val;
        idex_d.imm     = imm;
        idex_d.rs1     = rs1;
        idex_d.rs2     = rs2;
        idex_d.rd      = rd;
        idex_d.funct3  = funct3;
        idex_d.valid   = ifid.valid;
    end

    stage_reg #(.payload_t(scpu_pkg::idex_t)) u_idex_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (stall || redirect),
        .d      (idex_d),
        .q      (idex)
    );

endmodule

/* logic/execute_unit.sv */
`include "scpu_defs.svh"

module execute_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  scpu_pkg::idex_t       idex,
    scpu_fwd_if.ex_src            fwd_out,
    scpu_fwd_if.sink              fwd_in,
    output logic                  redirect,
    output logic [`SCPU_XLEN-1:0] redirect_pc,
    output scpu_pkg::exmem_t      exmem
);

    localparam int SHW = $clog2(`SCPU_XLEN);

    logic                  ex_tap, wb_tap;
    logic [`SCPU_XLEN-1:0] rs1_val, rs2_val, opb, alu_out, result;
    logic                  cond;
    scpu_pkg::exmem_t      exmem_d;

    assign ex_tap = fwd_in.ex_reg_write && fwd_in.ex_rd != '0;
    assign wb_tap = fwd_in.wb_reg_write && fwd_in.wb_rd != '0;

    // EX/MEM wins over MEM/WB, the younger value
    always_comb begin
        rs1_val = idex.rs1_val;
        if (ex_tap && fwd_in.ex_rd == idex.rs1) begin
            rs1_val = fwd_in.ex_result;
        end else if (wb_tap && fwd_in.wb_rd == idex.rs1) begin
            rs1_val = fwd_in.wb_data;
        end
        rs2_val = idex.rs2_val;
        if (ex_tap && fwd_in.ex_rd == idex.rs2) begin
            rs2_val = fwd_in.ex_result;
        end else if (wb_tap && fwd_in.wb_rd == idex.rs2) begin
            rs2_val = fwd_in.wb_data;
        end
    end

    assign opb = idex.ctrl.alu_src_imm ? idex.imm : rs2_val;

    always_comb begin
        case (idex.ctrl.alu_op)
            scpu_pkg::ALU_SUB:  alu_out = rs1_val - opb;
            scpu_pkg::ALU_AND:  alu_out = rs1_val & opb;
            scpu_pkg::ALU_OR:   alu_out = rs1_val | opb;
            scpu_pkg::ALU_XOR:  alu_out = rs1_val ^ opb;
            scpu_pkg::ALU_SLT:  alu_out = `SCPU_XLEN'($signed(rs1_val) < $signed(opb));
            scpu_pkg::ALU_SLTU: alu_out = `SCPU_XLEN'(rs1_val < opb);
            scpu_pkg::ALU_SLL:  alu_out = rs1_val << opb[SHW-1:0];
            scpu_pkg::ALU_SRL:  alu_out = rs1_val >> opb[SHW-1:0];
            scpu_pkg::ALU_SRA:  alu_out = $signed(rs1_val) >>> opb[SHW-1:0];
            default:            alu_out = rs1_val + opb;
        endcase
    end

    always_comb begin
        case (idex.funct3)
            `SCPU_F3_BEQ:  cond = rs1_val == rs2_val;
            `SCPU_F3_BNE:  cond = rs1_val != rs2_val;
            `SCPU_F3_BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
            `SCPU_F3_BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
            `SCPU_F3_BLTU: cond = rs1_val < rs2_val;
            `SCPU_F3_BGEU: cond = rs1_val >= rs2_val;
            default:       cond = 1'b0;
        endcase
    end

    assign redirect = idex.valid
                      && ((idex.ctrl.branch && cond) || idex.ctrl.jal || idex.ctrl.jalr);
    assign redirect_pc = idex.ctrl.jalr ? ((rs1_val + idex.imm) & ~`SCPU_XLEN'd1)
                                        : idex.pc + idex.imm;

    always_comb begin
        if (idex.ctrl.auipc) begin
            result = idex.pc + idex.imm;
        end else begin
            case (idex.ctrl.wb_sel)
                scpu_pkg::WB_IMM: result = idex.imm;
                scpu_pkg::WB_PC4: result = idex.pc + `SCPU_XLEN'd4;
                default:          result = alu_out;
            endcase
        end
    end

    always_comb begin
        exmem_d            = '0;
        exmem_d.reg_write  = idex.ctrl.reg_write;
        exmem_d.wb_sel     = idex.ctrl.wb_sel;
        exmem_d.mem_read   = idex.ctrl.mem_read;
        exmem_d.mem_write  = idex.ctrl.mem_write;
        exmem_d.result     = result;
        exmem_d.store_data = rs2_val;
        exmem_d.imm        = idex.imm;
        exmem_d.pc         = idex.pc;
        exmem_d.rd         = idex.rd;
        exmem_d.valid      = idex.valid;
    end

    stage_reg #(.payload_t(scpu_pkg::exmem_t)) u_exmem_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (exmem_d),
        .q      (exmem)
    );

    // a load's result is its address, so it is not forwarded from here
    assign fwd_out.ex_reg_write = exmem.valid && exmem.reg_write && !exmem.mem_read;
    assign fwd_out.ex_rd        = exmem.rd;
    assign fwd_out.ex_result    = exmem.result;

endmodule

/* logic/fetch_unit.sv */
`include "scpu_defs.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`SCPU_XLEN-1:0] redirect_pc,
    output logic [`SCPU_XLEN-1:0] pc,
    input  logic [`SCPU_ILEN-1:0] inst,
    output scpu_pkg::ifid_t       ifid
);

    scpu_pkg::ifid_t ifid_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `SCPU_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + `SCPU_XLEN'd4;  // predict not taken
        end
    end

    assign ifid_d = '{inst: inst, pc: pc, valid: 1'b1};

    stage_reg #(.payload_t(scpu_pkg::ifid_t)) u_ifid_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (stall),
        .bubble (redirect),
        .d      (ifid_d),
        .q      (ifid)
    );

endmodule

/* logic/mem_wb_unit.sv */
`include "scpu_defs.svh"

module mem_wb_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  scpu_pkg::exmem_t      exmem,
    input  logic [`SCPU_XLEN-1:0] data_in,
    output logic [`SCPU_XLEN-1:0] addr_out,
    output logic [`SCPU_XLEN-1:0] data_out,
    output logic                  mem_write,
    scpu_fwd_if.wb_src            fwd
);

    scpu_pkg::memwb_t memwb_d, memwb;

    assign addr_out  = exmem.result;
    assign data_out  = exmem.store_data;
    assign mem_write = exmem.valid && exmem.mem_write;

    always_comb begin
        memwb_d           = '0;
        memwb_d.reg_write = exmem.reg_write;
        memwb_d.wb_sel    = exmem.wb_sel;
        memwb_d.result    = exmem.result;
        memwb_d.load_data = exmem.mem_read ? data_in : '0;
        memwb_d.imm       = exmem.imm;
        memwb_d.pc        = exmem.pc;
        memwb_d.rd        = exmem.rd;
        memwb_d.valid     = exmem.valid;
    end

    stage_reg #(.payload_t(scpu_pkg::memwb_t)) u_memwb_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (memwb_d),
        .q      (memwb)
    );

    always_comb begin
        case (memwb.wb_sel)
            scpu_pkg::WB_IMM: fwd.wb_data = memwb.imm;
            scpu_pkg::WB_PC4: fwd.wb_data = memwb.pc + `SCPU_XLEN'd4;
            scpu_pkg::WB_MEM: fwd.wb_data = memwb.load_data;
            default:          fwd.wb_data = memwb.result;
        endcase
    end

    assign fwd.wb_reg_write = memwb.valid && memwb.reg_write;
    assign fwd.wb_rd        = memwb.rd;

endmodule

/* logic/reg_file.sv */
`include "scpu_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [`SCPU_RA_W-1:0] waddr,
    input  logic [`SCPU_XLEN-1:0] wdata,
    input  logic [`SCPU_RA_W-1:0] raddr1,
    input  logic [`SCPU_RA_W-1:0] raddr2,
    output logic [`SCPU_XLEN-1:0] rdata1,
    output logic [`SCPU_XLEN-1:0] rdata2,
    input  logic [`SCPU_RA_W-1:0] debug_addr,
    output logic [`SCPU_XLEN-1:0] debug_data
);

    logic [`SCPU_XLEN-1:0] regs [`SCPU_NREGS];
    logic                  wr_en;

    assign wr_en = we && waddr != '0;  // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SCPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through on every read port
    always_comb begin
        rdata1     = (wr_en && raddr1 == waddr) ? wdata : regs[raddr1];
        rdata2     = (wr_en && raddr2 == waddr) ? wdata : regs[raddr2];
        debug_data = (wr_en && debug_addr == waddr) ? wdata : regs[debug_addr];
    end

endmodule

/* logic/scpu.sv */
`include "scpu_defs.svh"

module scpu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`SCPU_ILEN-1:0] inst,
    output logic [`SCPU_XLEN-1:0] pc_out,
    input  logic [`SCPU_XLEN-1:0] data_in,
    output logic [`SCPU_XLEN-1:0] addr_out,
    output logic [`SCPU_XLEN-1:0] data_out,
    output logic                  mem_write,
    input  logic [`SCPU_RA_W-1:0] debug_reg_addr,
    output logic [`SCPU_XLEN-1:0] debug_reg_data
);

    logic                  stall;
    logic                  redirect;
    logic [`SCPU_XLEN-1:0] redirect_pc;
    scpu_pkg::ifid_t       ifid;
    scpu_pkg::idex_t       idex;
    scpu_pkg::exmem_t      exmem;

    scpu_fwd_if fwd_bus ();

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc_out),
        .inst        (inst),
        .ifid        (ifid)
    );

    decode_unit u_decode (
        .clk            (clk),
        .rst            (rst),
        .ifid           (ifid),
        .redirect       (redirect),
        .stall          (stall),
        .fwd            (fwd_bus.sink),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data),
        .idex           (idex)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst         (rst),
        .idex        (idex),
        .fwd_out     (fwd_bus.ex_src),
        .fwd_in      (fwd_bus.sink),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exmem       (exmem)
    );

    mem_wb_unit u_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .exmem     (exmem),
        .data_in   (data_in),
        .addr_out  (addr_out),
        .data_out  (data_out),
        .mem_write (mem_write),
        .fwd       (fwd_bus.wb_src)
    );

endmodule

/* logic/scpu_defs.svh */
`ifndef SCPU_DEFS_SVH
`define SCPU_DEFS_SVH

`define SCPU_XLEN      64
`define SCPU_ILEN      32
`define SCPU_RA_W      5
`define SCPU_NREGS     32
`define SCPU_RESET_PC  64'h0

`define SCPU_OP_LOAD   7'b0000011
`define SCPU_OP_STORE  7'b0100011
`define SCPU_OP_BRANCH 7'b1100011
`define SCPU_OP_JAL    7'b1101111
`define SCPU_OP_JALR   7'b1100111
`define SCPU_OP_LUI    7'b0110111
`define SCPU_OP_AUIPC  7'b0010111
`define SCPU_OP_IMM    7'b0010011
`define SCPU_OP_REG    7'b0110011

`define SCPU_F3_BEQ    3'b000
`define SCPU_F3_BNE    3'b001
`define SCPU_F3_BLT    3'b100
`define SCPU_F3_BGE    3'b101
`define SCPU_F3_BLTU   3'b110
`define SCPU_F3_BGEU   3'b111

`endif

/* logic/scpu_fwd_if.sv */
`include "scpu_defs.svh"

interface scpu_fwd_if;

    logic                  ex_reg_write;  // EX/MEM tap
    logic [`SCPU_RA_W-1:0] ex_rd;
    logic [`SCPU_XLEN-1:0] ex_result;
    logic                  wb_reg_write;  // MEM/WB tap, also the rf write port
    logic [`SCPU_RA_W-1:0] wb_rd;
    logic [`SCPU_XLEN-1:0] wb_data;

    modport ex_src (
        output ex_reg_write,
        output ex_rd,
        output ex_result
    );

    modport wb_src (
        output wb_reg_write,
        output wb_rd,
        output wb_data
    );

    modport sink (
        input ex_reg_write,
        input ex_rd,
        input ex_result,
        input wb_reg_write,
        input wb_rd,
        input wb_data
    );

endinterface

/* logic/scpu_pkg.sv */
`include "scpu_defs.svh"

package scpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_IMM,
        WB_PC4,
        WB_MEM
    } wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;  // operand b from imm
        alu_op_e alu_op;
        wb_sel_e wb_sel;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jal;
        logic    jalr;
        logic    auipc;
    } ctrl_t;

    typedef struct packed {
        logic [`SCPU_ILEN-1:0] inst;
        logic [`SCPU_XLEN-1:0] pc;
        logic                  valid;
    } ifid_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`SCPU_XLEN-1:0] pc;
        logic [`SCPU_XLEN-1:0] rs1_val;
        logic [`SCPU_XLEN-1:0] rs2_val;
        logic [`SCPU_XLEN-1:0] imm;
        logic [`SCPU_RA_W-1:0] rs1;
        logic [`SCPU_RA_W-1:0] rs2;
        logic [`SCPU_RA_W-1:0] rd;
        logic [2:0]            funct3;
        logic                  valid;
    } idex_t;

    typedef struct packed {
        logic                  reg_write;
        wb_sel_e               wb_sel;
        logic                  mem_read;
        logic                  mem_write;
        logic [`SCPU_XLEN-1:0] result;      // also the memory address
        logic [`SCPU_XLEN-1:0] store_data;
        logic [`SCPU_XLEN-1:0] imm;
        logic [`SCPU_XLEN-1:0] pc;
        logic [`SCPU_RA_W-1:0] rd;
        logic                  valid;
    } exmem_t;

    typedef struct packed {
        logic                  reg_write;
        wb_sel_e               wb_sel;
        logic [`SCPU_XLEN-1:0] result;
        logic [`SCPU_XLEN-1:0] load_data;
        logic [`SCPU_XLEN-1:0] imm;
        logic [`SCPU_XLEN-1:0] pc;
        logic [`SCPU_RA_W-1:0] rd;
        logic                  valid;
    } memwb_t;

endpackage

/* logic/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // zero payload doubles as the bubble, valid clear
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

/* scpu.f */
+incdir+logic
logic/scpu_pkg.sv
logic/scpu_fwd_if.sv
logic/stage_reg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/mem_wb_unit.sv
logic/scpu.sv
verification/scpu_checker.sv
verification/scpu_tb.sv

/* verification/scpu_checker.sv */
module scpu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] pc_out,
    input  logic        mem_write,
    input  logic [63:0] addr_out,
    input  logic [63:0] data_out,
    input  logic        reg_check,
    input  logic [4:0]  debug_reg_addr,
    input  logic [63:0] debug_reg_data,
    output logic        stores_done
);

    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [63:0] exp_reg [32];
    bit          exp_reg_set [32];
    int          store_idx = 0;
    int          mismatches = 0;
    int          failures = 0;
    bit          done_flag = 1'b0;
    bit          rst_prev = 1'b0;
    bit          reset_seen = 1'b0;

    assign stores_done = done_flag;

    task automatic expect_store(input logic [63:0] a, input logic [63:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic expect_reg(input logic [4:0] num, input logic [63:0] val);
        exp_reg[num]     = val;
        exp_reg_set[num] = 1'b1;
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR: %s", msg);
        failures++;
    endtask

    // sampled at the rising edge, outputs settled since the last one
    always @(posedge clk) begin
        if (reset_seen && $isunknown(mem_write)) begin
            note_failure("mem_write is unknown after reset was applied");
        end
        if (rst_prev && pc_out !== 64'h0) begin  // pc right after a reset edge
            $display("MISMATCH pc_out after reset: got %h expected %h", pc_out, 64'h0);
            mismatches++;
        end
        if (mem_write === 1'b1) begin
            if (rst) begin
                note_failure("store seen while reset is asserted");
            end else if (store_idx >= exp_addr.size()) begin
                note_failure($sformatf("extra store to address %h beyond the expected list",
                                       addr_out));
            end else begin
                if (addr_out !== exp_addr[store_idx]) begin
                    $display("MISMATCH store %0d addr_out: got %h expected %h",
                             store_idx, addr_out, exp_addr[store_idx]);
                    mismatches++;
                end
                if (data_out !== exp_data[store_idx]) begin
                    $display("MISMATCH store %0d data_out: got %h expected %h",
                             store_idx, data_out, exp_data[store_idx]);
                    mismatches++;
                end
                store_idx++;
                if (store_idx == exp_addr.size()) done_flag = 1'b1;  // last one seen
            end
        end
        if (reg_check === 1'b1) begin
            if (!exp_reg_set[debug_reg_addr]) begin
                note_failure($sformatf("no expected value for register x%0d", debug_reg_addr));
            end else if (debug_reg_data !== exp_reg[debug_reg_addr]) begin
                $display("MISMATCH x%0d debug_reg_data: got %h expected %h",
                         debug_reg_addr, debug_reg_data, exp_reg[debug_reg_addr]);
                mismatches++;
            end
        end
        rst_prev   = rst;
        reset_seen = reset_seen || rst;
    end

endmodule

/* verification/scpu_tb.sv */
module scpu_tb;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] inst;
    logic [63:0] pc_out;
    logic [63:0] data_in;
    logic [63:0] addr_out;
    logic [63:0] data_out;
    logic        mem_write;
    logic [4:0]  debug_reg_addr;
    logic [63:0] debug_reg_data;
    logic        reg_check;
    logic        stores_done;

    logic [31:0] imem [256];
    logic [63:0] dmem [256];
    logic [4:0]  reg_nums [$];
    int          n_prog = 0;
    int          n_stores = 0;
    int          cycles;
    int          limit;

    always #2 clk = ~clk;

    assign inst    = imem[pc_out[9:2]];   // word addressed
    assign data_in = dmem[addr_out[10:3]];

    always @(posedge clk) begin
        if (mem_write === 1'b1) dmem[addr_out[10:3]] <= data_out;
    end

    scpu scpu_inst (
        .clk            (clk),
        .rst            (rst),
        .inst           (inst),
        .pc_out         (pc_out),
        .data_in        (data_in),
        .addr_out       (addr_out),
        .data_out       (data_out),
        .mem_write      (mem_write),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data)
    );

    scpu_checker checker_inst (
        .clk            (clk),
        .rst            (rst),
        .pc_out         (pc_out),
        .mem_write      (mem_write),
        .addr_out       (addr_out),
        .data_out       (data_out),
        .reg_check      (reg_check),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data),
        .stores_done    (stores_done)
    );

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [63:0] a;
        logic [63:0] b;
        fd = $fopen("verification/scpu_trace.txt", "r");
        if (fd == 0) begin
            checker_inst.note_failure("cannot open verification/scpu_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line[0] == "#") continue;
            a = '0;
            b = '0;
            n = $sscanf(line, "%c %h %h", tag, a, b);
            case (tag)
                "P": begin
                    imem[n_prog] = a[31:0];
                    n_prog++;
                end
                "M": dmem[a[10:3]] = b;
                "S": begin
                    checker_inst.expect_store(a, b);
                    n_stores++;
                end
                "R": begin
                    reg_nums.push_back(a[4:0]);
                    checker_inst.expect_reg(a[4:0], b);
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    task automatic sweep_registers();
        foreach (reg_nums[k]) begin
            @(negedge clk);
            debug_reg_addr = reg_nums[k];
            reg_check      = 1'b1;
        end
        @(negedge clk);
        reg_check = 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        debug_reg_addr = '0;
        reg_check      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013 | (i << 20);      // addi x0, x0, i
            dmem[i] = 64'h5a5a_0f0f_0000_0000 | i;
        end
        load_trace();
        if (n_prog == 0 || n_stores == 0 || reg_nums.size() == 0) begin
            checker_inst.note_failure(
                "trace holds no program, no expected stores or no expected registers");
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        limit  = 4 * n_prog + 50;
        cycles = 0;
        while (!stores_done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!stores_done) begin
            checker_inst.note_failure("not all expected stores appeared before the cycle limit");
        end else begin
            repeat (8) @(negedge clk);
            sweep_registers();
        end
        @(negedge clk);
        $display("checks done: %0d mismatches, %0d failures",
                 checker_inst.mismatches, checker_inst.failures);
        if (checker_inst.mismatches == 0 && checker_inst.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/scpu_trace.txt */
# P <instruction word>          program, in order from address 0
# M <byte addr> <data>   initial data word   S <byte addr> <data>   expected store, in order
# R <register> <value>   expected final register value
P 00500093
P FFD00113
P 002081B3
P 40208233
P 001122B3
P 00113333
P 005093B3
P 00703023
P 00515433
P 405154B3
P 0020C533
P 0020E5B3
P 0020F633
P 03E09693
P 4046D713
P FFF0C793
P 0060B813
P 10000893
P 0008B903
P 00190993
P 0138B423
P 0088BA03
P 0148B823
P 00C08663
P 05A00F93
P 05A00F93
P 00209663
P 05A00F93
P 05A00F93
P 00114663
P 05A00F93
P 05A00F93
P 0020D663
P 05A00F93
P 05A00F93
P 0020E663
P 05A00F93
P 05A00F93
P 00117663
P 05A00F93
P 05A00F93
P 00208463
P 001B0B13
P 00C09463
P 001B0B13
P 0020C463
P 001B0B13
P 00115463
P 001B0B13
P 00116463
P 001B0B13
P 0020F463
P 001B0B13
P 00C00BEF
P 05A00F93
P 05A00F93
P 00000C17
P 011C0CE7
P 05A00F93
P 05A00F93
P ABCDED37
P 00708013
P 00100DB3
P 01A8BC23
P 0368B023
P 0000006F
M 100 1122334455667788
S 0 000000000000000A
S 108 1122334455667789
S 110 1122334455667789
S 118 FFFFFFFFABCDE000
S 120 0000000000000006
R 0 0000000000000000
R 1 0000000000000005
R 2 FFFFFFFFFFFFFFFD
R 3 0000000000000002
R 4 0000000000000008
R 5 0000000000000001
R 6 0000000000000000
R 7 000000000000000A
R 8 7FFFFFFFFFFFFFFE
R 9 FFFFFFFFFFFFFFFE
R A FFFFFFFFFFFFFFF8
R B FFFFFFFFFFFFFFFD
R C 0000000000000005
R D 4000000000000000
R E 0400000000000000
R F FFFFFFFFFFFFFFFA
R 10 0000000000000001
R 11 0000000000000100
R 12 1122334455667788
R 13 1122334455667789
R 14 1122334455667789
R 15 0000000000000000
R 16 0000000000000006
R 17 00000000000000D8
R 18 00000000000000E0
R 19 00000000000000E8
R 1A FFFFFFFFABCDE000
R 1B 0000000000000005
R 1F 0000000000000000
